// ==== synth.f ====
+incdir+include
hdl/synth_pkg.sv
hdl/synth_sequencer.sv
hdl/synth_cfg_regs.sv
hdl/saw_osc_bank.sv
hdl/svf_datapath.sv
hdl/pwm_dac.sv
hdl/synth_top.sv
verif/synth_frame_model.sv
verif/synth_tb.sv

// ==== verif/synth_tb.sv ====
`timescale 1ns/1ps
`include "synth_settings.svh"

module synth_tb;

	localparam int CLK_PERIOD   = 20;
	localparam int FRAME_CYCLES = 1 << `SYNTH_STEP_BITS;
	localparam int WRITE_STEP   = 8; // Writes land after the filter steps, before the PWM load
	localparam int TEST_FRAMES  = 1 + 40 + (8 + 200) + (1 + 100) + (8 + 100) + (4 + 100);

	logic                          clk;
	logic                          reset;
	synth_pkg::cfg_write_t         cfg_in;
	logic [`SYNTH_LEVEL_BITS-1:0]  level;
	logic                          pwm;
	logic [`SYNTH_LEVEL_BITS-1:0]  exp_level;
	logic [`SYNTH_STEP_BITS-1:0]   exp_pwm;

	int     cyc;        // Cycles since reset release
	int     pwm_high;   // Pwm-high cycles so far in this frame
	int     pwm_expect;
	int     pwm_next;
	int     level_errors;
	int     pwm_errors;
	int     other_errors;
	integer seed;

	synth_top i_dut (.clk(clk), .reset(reset), .cfg_in(cfg_in), .level(level), .pwm(pwm));

	synth_frame_model i_model (
		.clk       (clk),
		.reset     (reset),
		.cfg_in    (cfg_in),
		.exp_level (exp_level),
		.exp_pwm   (exp_pwm)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(2 * TEST_FRAMES * FRAME_CYCLES * CLK_PERIOD);
		$display("Watchdog expired before the tests completed");
		$display("TESTS FAILED");
		$finish;
	end

	// One cycle with the per-frame level and PWM checks
	// ==============================
	task automatic tick();
		int done_step;
		@(posedge clk);
		#2;
		done_step = cyc % FRAME_CYCLES;
		cyc++;
		if (done_step == 3) begin
			assert (level === exp_level) else begin
				$display("Fail level: got 0x%0h, expected 0x%0h", level, exp_level);
				level_errors++;
			end
			pwm_next = exp_pwm; // Loaded at the end of this frame
		end
		if (done_step == FRAME_CYCLES - 1) begin
			assert (pwm_high == pwm_expect) else begin
				$display("Fail pwm high count: got 0x%0h, expected 0x%0h", pwm_high, pwm_expect);
				pwm_errors++;
			end
			pwm_expect = pwm_next;
			pwm_high   = 0;
		end
		pwm_high += pwm;
	endtask

	task automatic run_frames(input int n);
		repeat (n * FRAME_CYCLES) tick();
	endtask

	task automatic start_write(input logic [2:0] addr, input logic hi, input logic [7:0] data);
		while (cyc % FRAME_CYCLES != WRITE_STEP)
			tick();
		cfg_in.addr = addr;
		cfg_in.hi   = hi;
		cfg_in.data = data;
		tick();
		cfg_in.strobe = 1'b1;
	endtask

	task automatic write_byte(input logic [2:0] addr, input logic hi, input logic [7:0] data);
		start_write(addr, hi, data);
		repeat (4) tick();
		cfg_in.strobe = 1'b0;
		repeat (4) tick();
	endtask

	task automatic write_word(input logic [2:0] addr, input logic [15:0] value);
		write_byte(addr, 1'b0, value[7:0]);
		write_byte(addr, 1'b1, value[15:8]);
	endtask

	// Directed tests
	// ==============================
	task automatic test_reset_state();
		repeat (FRAME_CYCLES) begin
			if (cyc <= 3)
				assert (level === 8'h80) else begin
					$display("Fail level: got 0x%0h, expected 0x80", level);
					level_errors++;
				end
			assert (pwm === 1'b0) else begin
				$display("Fail pwm: got 0x%0h, expected 0x0", pwm);
				pwm_errors++;
			end
			tick();
		end
	endtask

	task automatic test_byte_writes();
		write_word(3'd0, 16'h04A0); // Octave 2, period 0x0A0
		write_word(3'd4, 16'h0040); // Volume shift 2
		write_word(3'd2, 16'h0060); // Cutoff shift 3
		write_word(3'd3, 16'h0040); // Damp shift 2
		run_frames(200);
	endtask

	task automatic test_held_strobe();
		start_write(3'd4, 1'b0, 8'h60); // Volume shift 3
		repeat (4) tick();
		cfg_in.data = 8'hFF; // Ignored while the strobe stays high
		repeat (2) tick();
		cfg_in.data = 8'h01;
		repeat (2) tick();
		cfg_in.strobe = 1'b0;
		repeat (4) tick();
		run_frames(100);
	endtask

	task automatic test_saturation();
		bit reached;
		reached = 1'b0;
		write_word(3'd4, 16'h0000); // Volume 0
		write_word(3'd3, 16'h01E0); // Damp 15
		write_word(3'd2, 16'h0000); // Cutoff 0
		write_word(3'd0, 16'h0000); // Octave 0, shortest period
		repeat (100) begin
			run_frames(1);
			if (level == 8'hFF || level == 8'h00)
				reached = 1'b1;
		end
		assert (reached) else begin
			$display("Level never reached a rail with the saturating setup");
			other_errors++;
		end
	endtask

	task automatic test_random_oscs();
		logic [8:0] period;
		logic [3:0] octave;
		for (int i = 0; i < 2; i++) begin
			period = 9'($random(seed));
			octave = 4'($random(seed));
			write_word(3'(i), {3'b000, octave, period});
		end
		run_frames(100);
	endtask

	initial begin
		seed         = 17910;
		level_errors = 0;
		pwm_errors   = 0;
		other_errors = 0;
		cyc          = 0;
		pwm_expect   = 0;
		pwm_next     = 0;
		cfg_in       = '0;
		reset        = 1'b1;
		repeat (10) @(posedge clk);
		#2;
		reset    = 1'b0; // Step 0 of frame 0
		pwm_high = pwm;
		test_reset_state();
		run_frames(40); // Default configuration
		test_byte_writes();
		test_held_strobe();
		test_saturation();
		test_random_oscs();
		$display("Errors: level %0d, pwm %0d, other %0d", level_errors, pwm_errors, other_errors);
		if (level_errors + pwm_errors + other_errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

// ==== verif/synth_frame_model.sv ====
`timescale 1ns/1ps
`include "synth_settings.svh"

module synth_frame_model (
	input  logic                          clk,
	input  logic                          reset,
	input  synth_pkg::cfg_write_t         cfg_in,
	output logic [`SYNTH_LEVEL_BITS-1:0]  exp_level,
	output logic [`SYNTH_STEP_BITS-1:0]   exp_pwm
);

	localparam int FRAME_CYCLES = 1 << `SYNTH_STEP_BITS;
	localparam int STATE_MAX    = (1 << (`SYNTH_FSTATE_BITS - 1)) - 1;
	localparam int STATE_MIN    = -(1 << (`SYNTH_FSTATE_BITS - 1));
	localparam int SAW_LSB      = `SYNTH_SHIFTER_BITS - `SYNTH_WAVE_BITS - 1;
	localparam int LEVEL_SHIFT  = `SYNTH_FSTATE_BITS - `SYNTH_LEVEL_BITS;
	localparam int PWM_SHIFT    = `SYNTH_FSTATE_BITS - `SYNTH_STEP_BITS;

	logic [15:0] words [8];
	logic        last_strobe;
	int          step;
	int          divider;
	int          osc_cnt [2];
	int          osc_saw [2];
	int          y;
	int          v;

	function automatic int sat_add(input int a, input int b);
		int s;
		s = a + b;
		if (s > STATE_MAX)
			s = STATE_MAX;
		else if (s < STATE_MIN)
			s = STATE_MIN;
		return s;
	endfunction

	// Octave k plays when divider bit k-1 rises at the coming increment, never octave 15
	function automatic bit octave_on(input int oct);
		int nxt;
		nxt = (divider + 1) % (1 << `SYNTH_DIVIDER_BITS);
		if (oct == 0)
			return 1'b1;
		if (oct == 15)
			return 1'b0;
		return ((nxt >> (oct - 1)) & 1) && !((divider >> (oct - 1)) & 1);
	endfunction

	task automatic step_osc(input int i, output int saw_before);
		int period;
		int octave;
		period     = words[i] & 16'h01FF;
		octave     = (words[i] >> 9) & 15;
		saw_before = osc_saw[i];
		if (octave_on(octave)) begin
			if (((osc_cnt[i] >> 2) & 8'hFF) == 0) begin // Trigger and reload
				osc_saw[i] = (osc_saw[i] + 1) % 4;
				osc_cnt[i] = osc_cnt[i] + 512 + period;
			end
			osc_cnt[i] = (osc_cnt[i] - 4) & 10'h3FF;
		end
	endtask

	// Steps 0 to 4 and the PWM load of one frame
	// ==============================
	task automatic run_frame();
		int saw0;
		int saw1;
		int cutoff;
		int damp;
		int vol;
		int dith;
		int out;
		cutoff = (words[2] >> 5) & 15;
		damp   = (words[3] >> 5) & 15;
		vol    = (words[4] >> 5) & 15;
		step_osc(0, saw0);
		step_osc(1, saw1);
		v = sat_add(v, ((2 * saw0 - 3) * (1 << SAW_LSB)) >>> vol); // Centered saw
		v = sat_add(v, ((2 * saw1 - 3) * (1 << SAW_LSB)) >>> vol);
		v = sat_add(v, (~(v >>> 3)) >>> damp);
		y = sat_add(y, (v >>> 3) >>> cutoff);
		v = sat_add(v, (~(y >>> 3)) >>> cutoff);
		exp_level = 8'((y >>> LEVEL_SHIFT) + 128);
		dith = 0;
		for (int i = 0; i < 15; i++)
			if ((divider >> i) & 1)
				dith += 1 << (14 - i); // Reversed divider bits
		if ((divider >> 14) & 1)
			dith -= 1 << 15;
		out     = sat_add(y, dith);
		exp_pwm = 5'((out >>> PWM_SHIFT) + 16);
		divider = (divider + 1) % (1 << `SYNTH_DIVIDER_BITS);
	endtask

	always @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 8; i++)
				words[i] = 16'hFFFF;
			last_strobe = 1'b0;
			step        = 0;
			divider     = 0;
			osc_cnt     = '{0, 0};
			osc_saw     = '{0, 0};
			y           = 0;
			v           = 0;
			run_frame(); // Frame 0 starts when reset falls
		end else begin
			if (cfg_in.strobe && !last_strobe) begin
				if (cfg_in.hi)
					words[cfg_in.addr][15:8] = cfg_in.data;
				else
					words[cfg_in.addr][7:0] = cfg_in.data;
			end
			last_strobe = cfg_in.strobe;
			if (step == FRAME_CYCLES - 1)
				run_frame();
			step = (step + 1) % FRAME_CYCLES;
		end
	end

endmodule

// ==== hdl/synth_top.sv ====
`timescale 1ns/1ps
`include "synth_settings.svh"

module synth_top (
	input  logic                          clk,
	input  logic                          reset,
	input  synth_pkg::cfg_write_t         cfg_in,
	output logic [`SYNTH_LEVEL_BITS-1:0]  level,
	output logic                          pwm
);

	synth_pkg::seq_t                  seq;
	logic [15:0]                      oct_enables;
	logic [`SYNTH_SHIFTER_BITS-1:0]   dither;
	synth_pkg::voice_cfg_t            voice;
	logic [`SYNTH_WAVE_BITS-1:0]      saw;
	logic [`SYNTH_FSTATE_BITS-1:0]    next_state;

	// Control
	// ==============================
	synth_sequencer i_sequencer (
		.clk         (clk),
		.reset       (reset),
		.seq         (seq),
		.oct_enables (oct_enables),
		.dither      (dither)
	);

	synth_cfg_regs i_cfg_regs (
		.clk    (clk),
		.reset  (reset),
		.cfg_in (cfg_in),
		.voice  (voice)
	);

	// Datapath
	// ==============================
	saw_osc_bank i_osc_bank (
		.clk         (clk),
		.reset       (reset),
		.seq         (seq),
		.oct_enables (oct_enables),
		.osc         (voice.osc),
		.saw         (saw)
	);

	svf_datapath i_svf (
		.clk        (clk),
		.reset      (reset),
		.seq        (seq),
		.voice      (voice),
		.saw        (saw),
		.dither     (dither),
		.level      (level),
		.next_state (next_state)
	);

	pwm_dac i_pwm (
		.clk        (clk),
		.reset      (reset),
		.seq        (seq),
		.next_state (next_state),
		.pwm        (pwm)
	);

endmodule

// ==== hdl/pwm_dac.sv ====
`timescale 1ns/1ps
`include "synth_settings.svh"

module pwm_dac (
	input  logic                            clk,
	input  logic                            reset,
	input  synth_pkg::seq_t                 seq,
	input  logic [`SYNTH_FSTATE_BITS-1:0]   next_state,
	output logic                            pwm
);

	localparam int FS  = `SYNTH_FSTATE_BITS;
	localparam int CNT = `SYNTH_STEP_BITS;

	logic [CNT-1:0] pwm_cnt;

	assign pwm = (pwm_cnt != '0);

	always_ff @(posedge clk) begin
		if (reset)
			pwm_cnt <= '0;
		else if (seq.frame_end)
			pwm_cnt <= {~next_state[FS-1], next_state[FS-2 -: CNT-1]}; // Dithered y
		else
			pwm_cnt <= pwm_cnt - CNT'(pwm); // Stops at zero
	end

endmodule

// ==== hdl/svf_datapath.sv ====
`timescale 1ns/1ps
`include "synth_settings.svh"

module svf_datapath (
	input  logic                              clk,
	input  logic                              reset,
	input  synth_pkg::seq_t                   seq,
	input  synth_pkg::voice_cfg_t             voice,
	input  logic [`SYNTH_WAVE_BITS-1:0]       saw,
	input  logic [`SYNTH_SHIFTER_BITS-1:0]    dither,
	output logic [`SYNTH_LEVEL_BITS-1:0]      level,
	output logic [`SYNTH_FSTATE_BITS-1:0]     next_state
);

	localparam int FS       = `SYNTH_FSTATE_BITS;
	localparam int SH       = `SYNTH_SHIFTER_BITS;
	localparam int WAVE     = `SYNTH_WAVE_BITS;
	localparam int LSHR     = `SYNTH_LEAST_SHR;
	localparam int LVL      = `SYNTH_LEVEL_BITS;
	localparam int FEED_SHL = SH - WAVE;

	logic signed [FS-1:0]        y;
	logic signed [FS-1:0]        v;
	logic signed [FS-1:0]        a_src;
	logic signed [FS-1:0]        b_src;
	logic [SH-1:0]               shifter_src;
	logic [`SYNTH_OCT_BITS-1:0]  nf;
	synth_pkg::target_e          target;
	logic [FS-1:0]               sum;
	logic                        sat_max;
	logic                        sat_min;

	// Operand select per step
	// ==============================
	always_comb begin
		case (seq.step)
			synth_pkg::STEP_VOL0, synth_pkg::STEP_VOL1: begin
				target      = synth_pkg::TARGET_V;
				a_src       = v;
				// Centered saw keeps the filter away from one-sided saturation
				shifter_src = {~saw[WAVE-1], saw[WAVE-2:0], 1'b1, {(FEED_SHL-1){1'b0}}};
				nf          = voice.vol_shr;
			end
			synth_pkg::STEP_DAMP: begin
				target      = synth_pkg::TARGET_V;
				a_src       = v;
				shifter_src = ~v[FS-1:LSHR]; // Approximate negation
				nf          = voice.damp_shr;
			end
			synth_pkg::STEP_CUTOFF_Y: begin
				target      = synth_pkg::TARGET_Y;
				a_src       = y;
				shifter_src = v[FS-1:LSHR];
				nf          = voice.cutoff_shr;
			end
			synth_pkg::STEP_CUTOFF_V: begin
				target      = synth_pkg::TARGET_V;
				a_src       = v;
				shifter_src = ~y[FS-1:LSHR];
				nf          = voice.cutoff_shr;
			end
			synth_pkg::STEP_OUTPUT: begin
				target      = synth_pkg::TARGET_NONE; // Adder reused for PWM dither
				a_src       = y;
				shifter_src = dither;
				nf          = '0;
			end
			default: begin
				target      = synth_pkg::TARGET_NONE;
				a_src       = y;
				shifter_src = '0;
				nf          = '0;
			end
		endcase
	end

	// Shift and saturating add
	// ==============================
	assign b_src   = $signed({{LSHR{shifter_src[SH-1]}}, shifter_src}) >>> nf;
	assign sum     = a_src + b_src;
	assign sat_max = ~a_src[FS-1] & ~b_src[FS-1] &  sum[FS-1];
	assign sat_min =  a_src[FS-1] &  b_src[FS-1] & ~sum[FS-1];

	always_comb begin
		if (sat_max)
			next_state = {1'b0, {(FS-1){1'b1}}};
		else if (sat_min)
			next_state = {1'b1, {(FS-1){1'b0}}};
		else
			next_state = sum;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			y <= '0;
			v <= '0;
		end else begin
			if (target == synth_pkg::TARGET_Y)
				y <= next_state;
			if (target == synth_pkg::TARGET_V)
				v <= next_state;
		end
	end

	// Offset binary output
	assign level = {~y[FS-1], y[FS-2 -: LVL-1]};

endmodule

// ==== hdl/saw_osc_bank.sv ====
`timescale 1ns/1ps
`include "synth_settings.svh"

module saw_osc_bank (
	input  logic                                       clk,
	input  logic                                       reset,
	input  synth_pkg::seq_t                            seq,
	input  logic [15:0]                                oct_enables,
	input  synth_pkg::osc_cfg_t [`SYNTH_NUM_OSCS-1:0]  osc,
	output logic [`SYNTH_WAVE_BITS-1:0]                saw
);

	localparam int NUM_OSCS = `SYNTH_NUM_OSCS;
	localparam int IDX_BITS = $clog2(`SYNTH_NUM_OSCS);
	localparam int CNT_BITS = `SYNTH_OSC_PERIOD_BITS;
	localparam int WAVE     = `SYNTH_WAVE_BITS;
	localparam int OCTS     = 1 << `SYNTH_OCT_BITS;

	logic [`SYNTH_STEP_BITS-1:0] step_num;
	logic [IDX_BITS-1:0]         idx;
	logic                        update;
	logic [OCTS-1:0]             saw_oct_enables;
	logic                        en;
	logic                        trigger;
	logic [CNT_BITS-1:0]         curr_cnt;
	logic [CNT_BITS-1:0]         reload;
	logic [CNT_BITS-1:0]         delta;
	logic [CNT_BITS-1:0]         next_cnt;
	logic [CNT_BITS-1:0]         cnt     [NUM_OSCS];
	logic [WAVE-1:0]             saw_reg [NUM_OSCS];

	// Oscillator i is served at step i
	assign step_num = seq.step;
	assign idx      = step_num[IDX_BITS-1:0];
	assign update   = (step_num < NUM_OSCS);

	// Top octave is never enabled
	assign saw_oct_enables = {1'b0, oct_enables[OCTS-2:0]};
	assign en              = update & saw_oct_enables[osc[idx].octave];

	// Shared trigger and reload counter
	// ==============================
	assign curr_cnt = cnt[idx];
	assign trigger  = en & ~|curr_cnt[CNT_BITS-1:WAVE]; // Next step of 4 would wrap
	assign reload   = {1'b1, osc[idx].period};
	assign delta    = (trigger ? reload : '0) - CNT_BITS'(1 << WAVE);
	assign next_cnt = curr_cnt + delta;

	assign saw = saw_reg[idx]; // Value before this step's update

	// Per-oscillator state
	// ==============================
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < NUM_OSCS; i++) begin
				cnt[i]     <= '0;
				saw_reg[i] <= '0;
			end
		end else begin
			for (int i = 0; i < NUM_OSCS; i++) begin
				if (en && idx == i) begin
					cnt[i]     <= next_cnt;
					saw_reg[i] <= saw_reg[i] + WAVE'(trigger);
				end
			end
		end
	end

endmodule

// ==== hdl/synth_cfg_regs.sv ====
`timescale 1ns/1ps
`include "synth_settings.svh"

module synth_cfg_regs (
	input  logic                    clk,
	input  logic                    reset,
	input  synth_pkg::cfg_write_t   cfg_in,
	output synth_pkg::voice_cfg_t   voice
);

	localparam int CFG_WORDS  = 1 << `SYNTH_CFG_ADDR_BITS;
	localparam int NUM_OSCS   = `SYNTH_NUM_OSCS;
	localparam int NUM_MODS   = `SYNTH_NUM_FILTER_MODS;
	localparam int OCT_BITS   = `SYNTH_OCT_BITS;
	localparam int PER_BITS   = `SYNTH_OSC_PERIOD_BITS - 1;
	localparam int SHR_LSB    = 5; // Shift amount sits in bits 8:5 of a filter word
	localparam int CUTOFF_IDX = 0;
	localparam int DAMP_IDX   = 1;
	localparam int VOL_IDX    = 2;

	logic [1:0]  strobe_sync;
	logic        prev_strobe;
	logic        strobed;
	logic [15:0] words [CFG_WORDS];
	logic [OCT_BITS-1:0] shr [NUM_MODS];

	// Strobe synchronizer and edge detect
	// ==============================
	always_ff @(posedge clk) begin
		if (reset) begin
			strobe_sync <= '0;
			prev_strobe <= 1'b0;
		end else begin
			strobe_sync <= {strobe_sync[0], cfg_in.strobe};
			prev_strobe <= strobe_sync[1];
		end
	end

	assign strobed = strobe_sync[1] & ~prev_strobe; // One write per strobe

	// Configuration words
	// ==============================
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < CFG_WORDS; i++)
				words[i] <= '1; // Octave 15 keeps both oscillators silent
		end else if (strobed) begin
			if (cfg_in.hi)
				words[cfg_in.addr][15:8] <= cfg_in.data;
			else
				words[cfg_in.addr][7:0] <= cfg_in.data;
		end
	end

	// Field extraction
	always_comb begin
		for (int i = 0; i < NUM_OSCS; i++) begin
			voice.osc[i].period = words[i][PER_BITS-1:0];
			voice.osc[i].octave = words[i][PER_BITS +: OCT_BITS];
		end
		for (int m = 0; m < NUM_MODS; m++)
			shr[m] = words[NUM_OSCS+m][SHR_LSB +: OCT_BITS]; // Filter words follow the oscillators
		voice.cutoff_shr = shr[CUTOFF_IDX];
		voice.damp_shr   = shr[DAMP_IDX];
		voice.vol_shr    = shr[VOL_IDX];
	end

endmodule

// ==== hdl/synth_sequencer.sv ====
`timescale 1ns/1ps
`include "synth_settings.svh"

module synth_sequencer (
	input  logic                            clk,
	input  logic                            reset,
	output synth_pkg::seq_t                 seq,
	output logic [15:0]                     oct_enables,
	output logic [`SYNTH_SHIFTER_BITS-1:0]  dither
);

	localparam int STEP_BITS = `SYNTH_STEP_BITS;
	localparam int DIV_BITS  = `SYNTH_DIVIDER_BITS;
	localparam int DIT_BITS  = `SYNTH_DITHER_BITS;
	localparam int SH_BITS   = `SYNTH_SHIFTER_BITS;

	logic [STEP_BITS-1:0] step_cnt;
	logic [DIV_BITS-1:0]  oct_cnt;
	logic [DIV_BITS-1:0]  next_oct_cnt;
	logic                 frame_end;

	// Step counter and octave divider
	// ==============================
	assign frame_end    = (step_cnt == '1);
	assign next_oct_cnt = oct_cnt + 1'b1;

	always_ff @(posedge clk) begin
		if (reset) begin
			step_cnt <= '0;
			oct_cnt  <= '0;
		end else begin
			step_cnt <= step_cnt + 1'b1; // Wraps every 32 cycles
			if (frame_end)
				oct_cnt <= next_oct_cnt;
		end
	end

	assign seq.step      = synth_pkg::step_e'(step_cnt);
	assign seq.frame_end = frame_end;

	// Octave k runs at half the rate of octave k-1
	assign oct_enables[0]          = 1'b1;
	assign oct_enables[DIV_BITS:1] = next_oct_cnt & ~oct_cnt; // Bits that carry into one

	// Dither word
	// ==============================
	always_comb begin
		dither[SH_BITS-1:DIT_BITS] = {(SH_BITS-DIT_BITS){oct_cnt[DIT_BITS-1]}}; // Sign extend
		for (int i = 0; i < DIT_BITS; i++)
			dither[i] = oct_cnt[DIT_BITS-1-i]; // Bit reversed divider
	end

endmodule

// ==== hdl/synth_pkg.sv ====
`include "synth_settings.svh"

package synth_pkg;

	// Filter schedule within one 32-cycle frame
	typedef enum logic [`SYNTH_STEP_BITS-1:0] {
		STEP_VOL0     = 5'd0, // Differs from STEP_VOL1 in bit 0 only
		STEP_VOL1     = 5'd1,
		STEP_DAMP     = 5'd2,
		STEP_CUTOFF_Y = 5'd3,
		STEP_CUTOFF_V = 5'd4,
		STEP_OUTPUT   = 5'd31
	} step_e;

	typedef enum logic [1:0] {
		TARGET_Y    = 2'd0,
		TARGET_V    = 2'd1,
		TARGET_NONE = 2'd2
	} target_e;

	typedef struct packed {
		step_e step;
		logic  frame_end; // Last cycle of the frame
	} seq_t;

	typedef struct packed {
		logic [`SYNTH_OSC_PERIOD_BITS-2:0] period; // Leading one is implied
		logic [`SYNTH_OCT_BITS-1:0]        octave;
	} osc_cfg_t;

	typedef struct packed {
		osc_cfg_t [`SYNTH_NUM_OSCS-1:0] osc;
		logic [`SYNTH_OCT_BITS-1:0]     cutoff_shr;
		logic [`SYNTH_OCT_BITS-1:0]     damp_shr;
		logic [`SYNTH_OCT_BITS-1:0]     vol_shr;
	} voice_cfg_t;

	typedef struct packed {
		logic [7:0]                      data;
		logic [`SYNTH_CFG_ADDR_BITS-1:0] addr;
		logic                            hi;     // Selects bits 15:8 of the word
		logic                            strobe; // Asynchronous, written on rising edge
	} cfg_write_t;

endpackage

// ==== include/synth_settings.svh ====
`ifndef SYNTH_SETTINGS_SVH
`define SYNTH_SETTINGS_SVH

// Sequencer
`define SYNTH_STEP_BITS 5
`define SYNTH_DIVIDER_BITS 15

// Oscillators
`define SYNTH_OCT_BITS 4
`define SYNTH_WAVE_BITS 2
`define SYNTH_OSC_PERIOD_BITS 10
`define SYNTH_NUM_OSCS 2

// Configuration words
`define SYNTH_NUM_FILTER_MODS 3
`define SYNTH_CFG_ADDR_BITS 3

// Filter state, wave bits plus least shift plus 15 guard bits
`define SYNTH_LEAST_SHR 3
`define SYNTH_FSTATE_BITS 20
`define SYNTH_SHIFTER_BITS 17
`define SYNTH_DITHER_BITS 15

`define SYNTH_LEVEL_BITS 8

`endif
